// ==== sim.f ====
+incdir+rtl
rtl/opn_pkg.sv
rtl/opn_wr_if.sv
rtl/opn_phase_gen.sv
rtl/opn_write_sync.sv
rtl/opn_io.sv
rtl/opn_reg_file.sv
rtl/opn_timers.sv
rtl/opn_top.sv
test/tb_opn_top.sv

// ==== Bender.yml ====
package:
  name: opn_bus_if

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/opn_pkg.sv
      - rtl/opn_wr_if.sv
      - rtl/opn_phase_gen.sv
      - rtl/opn_write_sync.sv
      - rtl/opn_io.sv
      - rtl/opn_reg_file.sv
      - rtl/opn_timers.sv
      - rtl/opn_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_opn_top.sv

// ==== test/opn_golden.txt ====
# test op operands, every value after the op is hex
# W addr data | R addr expected mask | D pg eg eg_inc op ch | I irq_n | P internal cycles
1 R 0 00 ff
1 I 1
2 W 1 00
2 R 0 80 80
2 P 28
2 R 0 00 80
3 W 0 24
3 W 1 ff
3 W 0 25
3 W 1 00
3 W 0 27
3 W 1 05
3 P 4
3 R 0 01 03
3 I 0
3 W 1 10
3 I 1
4 W 0 26
4 W 1 fe
4 W 0 27
4 W 1 0a
4 P 28
4 R 0 02 03
4 W 1 20
4 I 1
5 D 1 0 1 1234 1c3
5 W 0 21
5 W 1 c0
5 R 0 d2 ff
5 W 1 40
5 R 0 34 ff
5 W 0 2c
5 W 1 10
5 R 0 c3 ff
5 W 0 21
5 W 1 00
6 W 0 27
6 W 2 27
6 W 3 05
6 P 14
6 R 0 00 03
6 I 1

// ==== test/tb_opn_top.sv ====
`timescale 1ns/1ns
`include "opn_cfg.svh"

module tb_opn_top;

	logic MCLK;
	logic rst_n_i;
	logic cs_n_i;
	logic wr_n_i;
	logic rd_n_i;
	logic [1:0] addr_i;
	logic [7:0] data_i;
	logic pg_dbg_i;
	logic eg_dbg_i;
	logic eg_dbg_inc_i;
	logic [13:0] op_dbg_i;
	logic [8:0] ch_dbg_i;
	logic [7:0] data_o;
	logic data_oe_o;
	logic irq_n_o;

	string lines[$];
	int cycles = 0;
	int limit = 0;
	int test = 0;
	int test_errs = 0;
	int passed = 0;
	int failed = 0;

	opn_top i_opn_top (.*);

	initial begin
		MCLK = 1'b0;
		forever #20 MCLK = ~MCLK;
	end

	always @(posedge MCLK) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout after %0d MCLK cycles, the golden sequence did not finish.", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n * `OPN_CLK_DIV) @(negedge MCLK); // One internal cycle is six MCLK.
	endtask

	task automatic write_cycle(input logic [1:0] a, input logic [7:0] d);
		addr_i = a;
		data_i = d;
		{cs_n_i, wr_n_i} = 2'b00;
		wait_cycles(4);
		{cs_n_i, wr_n_i} = 2'b11;
		wait_cycles(4); // Leaves room for the strobe before the next write.
	endtask

	task automatic read_check(input logic [1:0] a, input logic [7:0] exp, input logic [7:0] mask);
		addr_i = a;
		{cs_n_i, rd_n_i} = 2'b00;
		@(negedge MCLK);
		assert (data_oe_o === 1'b1 && (data_o & mask) === (exp & mask)) else begin
			$display("CHECK FAILED at %0t: read 0x%02h with data_oe_o %b, expected 0x%02h mask 0x%02h",
				$time, data_o, data_oe_o, exp, mask);
			test_errs++;
		end
		{cs_n_i, rd_n_i} = 2'b11;
		wait_cycles(1);
	endtask

	task automatic report_test();
		if (test_errs == 0) begin
			$display("Test %0d passed", test);
			passed++;
		end else begin
			$display("Test %0d FAILED with %0d errors", test, test_errs);
			failed++;
		end
	endtask

	initial begin
		int fd;
		int n;
		int num;
		int waits;
		string line;
		string op;
		byte opc;
		logic [31:0] v [0:4];

		rst_n_i = 1'b0;
		{cs_n_i, wr_n_i, rd_n_i} = 3'b111;
		{addr_i, data_i} = '0;
		{pg_dbg_i, eg_dbg_i, eg_dbg_inc_i, op_dbg_i, ch_dbg_i} = '0;
		waits = 0;

		fd = $fopen("test/opn_golden.txt", "r");
		if (fd == 0) begin
			$display("The golden file test/opn_golden.txt could not be opened.");
			failed++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%d %s %h", num, op, v[0]);
					if (n < 2) begin
						$display("Malformed golden line skipped: %s", line);
						failed++;
					end else begin
						lines.push_back(line);
						waits += (op == "P") ? 8 + v[0] : 8;
					end
				end
			end
			$fclose(fd);
		end
		limit = waits * `OPN_CLK_DIV + 200;

		repeat (5) @(negedge MCLK);
		rst_n_i = 1'b1;

		foreach (lines[i]) begin
			n = $sscanf(lines[i], "%d %s %h %h %h %h %h", num, op, v[0], v[1], v[2], v[3], v[4]);
			if (num != test) begin
				if (test != 0)
					report_test();
				test = num;
				test_errs = 0;
			end
			opc = (op.len() == 1) ? op[0] : 8'h00;
			case (opc)
				"W": write_cycle(v[0][1:0], v[1][7:0]);
				"R": read_check(v[0][1:0], v[1][7:0], v[2][7:0]);
				"D": begin
					{pg_dbg_i, eg_dbg_i, eg_dbg_inc_i} = {v[0][0], v[1][0], v[2][0]};
					op_dbg_i = v[3][13:0];
					ch_dbg_i = v[4][8:0]; // Delayed by one internal cycle in the DUT.
				end
				"I": begin
					assert (irq_n_o === v[0][0] && data_oe_o === 1'b0) else begin
						$display("CHECK FAILED at %0t: irq_n_o %b data_oe_o %b, expected irq_n_o %b",
							$time, irq_n_o, data_oe_o, v[0][0]);
						test_errs++;
					end
				end
				"P": wait_cycles(v[0]);
				default: begin
					$display("Unknown operation '%s' in golden line: %s", op, lines[i]);
					test_errs++;
				end
			endcase
		end
		if (test != 0)
			report_test();

		$display("Tests passed: %0d, tests failed: %0d", passed, failed);
		if (failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== rtl/opn_top.sv ====
`timescale 1ns/1ns

module opn_top (
	input  logic MCLK,
	input  logic rst_n_i,
	input  logic cs_n_i,
	input  logic wr_n_i,
	input  logic rd_n_i,
	input  logic [1:0] addr_i,
	input  logic [7:0] data_i,
	input  logic pg_dbg_i,
	input  logic eg_dbg_i,
	input  logic eg_dbg_inc_i,
	input  logic [13:0] op_dbg_i,
	input  logic [8:0] ch_dbg_i,
	output logic [7:0] data_o,
	output logic data_oe_o,
	output logic irq_n_o
);

	logic c1;
	logic c2;
	logic flag_a;
	logic flag_b;
	logic ch_dbg_sel;
	logic ctrl_wr;
	logic [9:0] timer_a_val;
	logic [7:0] timer_b_val;
	opn_pkg::test_reg_t test_reg;
	opn_pkg::timer_ctrl_t timer_ctrl;

	opn_wr_if wr_if ();

	opn_phase_gen i_phase_gen (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.c1_o(c1),
		.c2_o(c2)
	);

	opn_io i_io (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.c1_i(c1),
		.c2_i(c2),
		.cs_n_i(cs_n_i),
		.wr_n_i(wr_n_i),
		.rd_n_i(rd_n_i),
		.addr_i(addr_i),
		.data_i(data_i),
		.flag_a_i(flag_a),
		.flag_b_i(flag_b),
		.test_reg_i(test_reg),
		.ch_dbg_sel_i(ch_dbg_sel),
		.pg_dbg_i(pg_dbg_i),
		.eg_dbg_i(eg_dbg_i),
		.eg_dbg_inc_i(eg_dbg_inc_i),
		.op_dbg_i(op_dbg_i),
		.ch_dbg_i(ch_dbg_i),
		.wr_if(wr_if.src),
		.data_o(data_o),
		.data_oe_o(data_oe_o),
		.irq_n_o(irq_n_o)
	);

	opn_reg_file i_reg_file (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.wr_if(wr_if.dst),
		.test_reg_o(test_reg),
		.ch_dbg_sel_o(ch_dbg_sel),
		.timer_a_val_o(timer_a_val),
		.timer_b_val_o(timer_b_val),
		.timer_ctrl_o(timer_ctrl),
		.ctrl_wr_o(ctrl_wr)
	);

	opn_timers i_timers (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.c2_i(c2),
		.timer_a_val_i(timer_a_val),
		.timer_b_val_i(timer_b_val),
		.timer_ctrl_i(timer_ctrl),
		.ctrl_wr_i(ctrl_wr),
		.flag_a_o(flag_a),
		.flag_b_o(flag_b)
	);

endmodule

// ==== rtl/opn_timers.sv ====
`timescale 1ns/1ns
`include "opn_cfg.svh"

module opn_timers (
	input  logic MCLK,
	input  logic rst_n_i,
	input  logic c2_i,
	input  logic [9:0] timer_a_val_i,
	input  logic [7:0] timer_b_val_i,
	input  opn_pkg::timer_ctrl_t timer_ctrl_i,
	input  logic ctrl_wr_i,
	output logic flag_a_o,
	output logic flag_b_o
);

	localparam logic [3:0] PRESC_LAST = 4'(`OPN_TIMER_B_DIV - 1);

	logic [9:0] cnt_a;
	logic [7:0] cnt_b;
	logic [3:0] presc;
	logic load_a_q;
	logic load_b_q;
	logic tick_b;

	assign tick_b = (presc == PRESC_LAST);

	always_ff @(posedge MCLK) begin
		if (!rst_n_i) begin
			cnt_a <= '0;
			cnt_b <= '0;
			presc <= '0;
			load_a_q <= 1'b0;
			load_b_q <= 1'b0;
			flag_a_o <= 1'b0;
			flag_b_o <= 1'b0;
		end else if (c2_i) begin
			load_a_q <= timer_ctrl_i.load_a;
			load_b_q <= timer_ctrl_i.load_b;
			presc <= tick_b ? 4'd0 : presc + 4'd1; // Free running.

			if (timer_ctrl_i.load_a && !load_a_q) begin
				cnt_a <= timer_a_val_i;
			end else if (timer_ctrl_i.load_a) begin
				if (&cnt_a) begin
					cnt_a <= timer_a_val_i;
					if (timer_ctrl_i.en_a)
						flag_a_o <= 1'b1;
				end else begin
					cnt_a <= cnt_a + 10'd1;
				end
			end

			if (timer_ctrl_i.load_b && !load_b_q) begin
				cnt_b <= timer_b_val_i;
			end else if (timer_ctrl_i.load_b && tick_b) begin
				if (&cnt_b) begin
					cnt_b <= timer_b_val_i;
					if (timer_ctrl_i.en_b)
						flag_b_o <= 1'b1;
				end else begin
					cnt_b <= cnt_b + 8'd1;
				end
			end

			// A reset bit in the same write wins over an overflow.
			if (ctrl_wr_i && timer_ctrl_i.rst_a)
				flag_a_o <= 1'b0;
			if (ctrl_wr_i && timer_ctrl_i.rst_b)
				flag_b_o <= 1'b0;
		end
	end

endmodule

// ==== rtl/opn_reg_file.sv ====
`timescale 1ns/1ns
`include "opn_cfg.svh"

module opn_reg_file (
	input  logic MCLK,
	input  logic rst_n_i,
	opn_wr_if.dst wr_if,
	output opn_pkg::test_reg_t test_reg_o,
	output logic ch_dbg_sel_o,
	output logic [9:0] timer_a_val_o,
	output logic [7:0] timer_b_val_o,
	output opn_pkg::timer_ctrl_t timer_ctrl_o,
	output logic ctrl_wr_o
);

	opn_pkg::reg_addr_t addr_q;
	logic addr_wr0;
	logic data_wr0;
	logic [7:0] ta_hi_q;
	logic [1:0] ta_lo_q;

	// Bank 1 writes go to registers that are not modelled here.
	assign addr_wr0 = wr_if.addr_wr & ~wr_if.bank;
	assign data_wr0 = wr_if.data_wr & ~wr_if.bank;

	always_ff @(posedge MCLK) begin
		if (!rst_n_i) begin
			addr_q <= '0;
			test_reg_o <= '0;
			ch_dbg_sel_o <= 1'b0;
			ta_hi_q <= '0;
			ta_lo_q <= '0;
			timer_b_val_o <= '0;
			timer_ctrl_o <= '0;
		end else begin
			if (addr_wr0)
				addr_q <= wr_if.wdata;
			if (data_wr0) begin
				case (addr_q)
					`OPN_REG_TEST: test_reg_o <= wr_if.wdata;
					`OPN_REG_TA_HI: ta_hi_q <= wr_if.wdata;
					`OPN_REG_TA_LO: ta_lo_q <= wr_if.wdata[1:0];
					`OPN_REG_TB: timer_b_val_o <= wr_if.wdata;
					`OPN_REG_TIMER_CTRL: timer_ctrl_o <= wr_if.wdata;
					`OPN_REG_DEBUG: ch_dbg_sel_o <= wr_if.wdata[4];
					default: ;
				endcase
			end
		end
	end

	assign timer_a_val_o = {ta_hi_q, ta_lo_q}; // 0x24 holds the upper eight bits.
	assign ctrl_wr_o = data_wr0 & (addr_q == `OPN_REG_TIMER_CTRL);

endmodule

// ==== rtl/opn_io.sv ====
`timescale 1ns/1ns
`include "opn_cfg.svh"

module opn_io (
	input  logic MCLK,
	input  logic rst_n_i,
	input  logic c1_i,
	input  logic c2_i,
	input  logic cs_n_i,
	input  logic wr_n_i,
	input  logic rd_n_i,
	input  logic [1:0] addr_i,
	input  logic [7:0] data_i,
	input  logic flag_a_i,
	input  logic flag_b_i,
	input  opn_pkg::test_reg_t test_reg_i,
	input  logic ch_dbg_sel_i,
	input  logic pg_dbg_i,
	input  logic eg_dbg_i,
	input  logic eg_dbg_inc_i,
	input  logic [13:0] op_dbg_i,
	input  logic [8:0] ch_dbg_i,
	opn_wr_if.src wr_if,
	output logic [7:0] data_o,
	output logic data_oe_o,
	output logic irq_n_o
);

	localparam logic [4:0] BUSY_LAST = 5'(`OPN_BUSY_CYCLES - 2);

	logic wr_active;
	logic read_en;
	logic [8:0] data_l;
	logic busy_q;
	logic busy;
	logic [4:0] busy_cnt;
	logic flag_a_l;
	logic flag_b_l;
	logic [8:0] ch_dbg_q;
	logic [15:0] dbg_word;
	logic [7:0] dbg_byte;

	assign wr_active = ~wr_n_i & ~cs_n_i;
	assign read_en = ~rd_n_i & ~cs_n_i & rst_n_i;

	opn_write_sync i_addr_sync (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.c1_i(c1_i),
		.c2_i(c2_i),
		.req_i(wr_active & ~addr_i[0]),
		.strobe_o(wr_if.addr_wr)
	);

	opn_write_sync i_data_sync (
		.MCLK(MCLK),
		.rst_n_i(rst_n_i),
		.c1_i(c1_i),
		.c2_i(c2_i),
		.req_i(wr_active & addr_i[0]),
		.strobe_o(wr_if.data_wr)
	);

	// Transparent while the host writes, so it keeps the last byte.
	always_ff @(posedge MCLK) begin
		if (wr_active)
			data_l <= {addr_i[1], data_i};
	end

	assign wr_if.wdata = data_l[7:0];
	assign wr_if.bank = data_l[8];

	always_ff @(posedge MCLK) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			busy_cnt <= '0;
		end else if (c2_i) begin
			if (wr_if.data_wr) begin
				busy_q <= 1'b1;
				busy_cnt <= '0;
			end else if (busy_q) begin
				busy_cnt <= busy_cnt + 5'd1;
				if (busy_cnt == BUSY_LAST)
					busy_q <= 1'b0;
			end
		end
	end

	assign busy = busy_q | wr_if.data_wr; // The strobe cycle counts as the first.

	// Flags are frozen for the duration of a read.
	always_ff @(posedge MCLK) begin
		if (!rst_n_i) begin
			flag_a_l <= 1'b0;
			flag_b_l <= 1'b0;
		end else if (!read_en) begin
			flag_a_l <= flag_a_i;
			flag_b_l <= flag_b_i;
		end
	end

	always_ff @(posedge MCLK) begin
		if (c2_i)
			ch_dbg_q <= ch_dbg_i;
	end

	assign dbg_word[15] = pg_dbg_i;
	assign dbg_word[14] = test_reg_i.eg_sel ? eg_dbg_i : eg_dbg_inc_i;
	assign dbg_word[13:0] = ch_dbg_sel_i ? {5'd0, ch_dbg_q} : op_dbg_i;
	assign dbg_byte = test_reg_i.dbg_hi ? dbg_word[15:8] : dbg_word[7:0];

	always_comb begin
		data_o = 8'h00;
		if (read_en) begin
			if (test_reg_i.dbg_en)
				data_o = dbg_byte;
			else
				data_o = {busy, 5'd0, flag_b_l, flag_a_l};
		end
	end

	assign data_oe_o = read_en;
	assign irq_n_o = ~(flag_a_l | flag_b_l);

endmodule

// ==== rtl/opn_write_sync.sv ====
`timescale 1ns/1ns

module opn_write_sync (
	input  logic MCLK,
	input  logic rst_n_i,
	input  logic c1_i,
	input  logic c2_i,
	input  logic req_i,
	output logic strobe_o
);

	logic trig_q; // Catches the host request at any time.
	logic sync_q;
	logic sig_q;
	logic sig_dly_q;

	always_ff @(posedge MCLK) begin
		if (!rst_n_i) begin
			trig_q <= 1'b0;
			sync_q <= 1'b0;
			sig_q <= 1'b0;
			sig_dly_q <= 1'b0;
		end else begin
			trig_q <= req_i | (trig_q & ~sig_q); // Set wins while the write is held.
			if (c1_i)
				sync_q <= trig_q;
			if (c2_i) begin
				sig_q <= sync_q;
				sig_dly_q <= sig_q;
			end
		end
	end

	// Rising edge of the synchronised request.
	assign strobe_o = sig_q & ~sig_dly_q;

endmodule

// ==== rtl/opn_phase_gen.sv ====
`timescale 1ns/1ns
`include "opn_cfg.svh"

module opn_phase_gen (
	input  logic MCLK,
	input  logic rst_n_i,
	output logic c1_o,
	output logic c2_o
);

	localparam logic [2:0] CNT_LAST = 3'(`OPN_CLK_DIV - 1);

	logic [2:0] cnt;

	always_ff @(posedge MCLK) begin
		if (!rst_n_i) begin
			cnt <= '0;
			c1_o <= 1'b0;
			c2_o <= 1'b0;
		end else begin
			cnt <= (cnt == CNT_LAST) ? 3'd0 : cnt + 3'd1;
			// Outputs are registered, so they go high one MCLK later.
			c1_o <= (cnt == CNT_LAST);
			c2_o <= (cnt == 3'd2);
		end
	end

endmodule

// ==== rtl/opn_wr_if.sv ====
`timescale 1ns/1ns

interface opn_wr_if;

	logic addr_wr; // One internal cycle, c2 to c2.
	logic data_wr;
	logic [7:0] wdata;
	logic bank; // Address bit 1 of the last write.

	modport src (
		output addr_wr,
		output data_wr,
		output wdata,
		output bank
	);

	modport dst (
		input addr_wr,
		input data_wr,
		input wdata,
		input bank
	);

endinterface

// ==== rtl/opn_pkg.sv ====
package opn_pkg;

	typedef logic [7:0] reg_addr_t;

	// Test register 0x21.
	typedef struct packed {
		logic dbg_hi; // Return the high byte of the debug word.
		logic dbg_en; // Reads return debug data instead of status.
		logic [4:0] reserved;
		logic eg_sel;
	} test_reg_t;

	// Timer control register 0x27.
	typedef struct packed {
		logic [1:0] mode;
		logic rst_b;
		logic rst_a;
		logic en_b;
		logic en_a;
		logic load_b;
		logic load_a;
	} timer_ctrl_t;

endpackage

// ==== rtl/opn_cfg.svh ====
`ifndef OPN_CFG_SVH
`define OPN_CFG_SVH

// MCLK cycles per internal cycle. c1 falls at count 0, c2 at count 3.
`define OPN_CLK_DIV 6
`define OPN_BUSY_CYCLES 32 // Internal cycles of busy after a data write.
`define OPN_TIMER_B_DIV 16

`define OPN_REG_TEST 8'h21
`define OPN_REG_TA_HI 8'h24
`define OPN_REG_TA_LO 8'h25
`define OPN_REG_TB 8'h26
`define OPN_REG_TIMER_CTRL 8'h27
`define OPN_REG_DEBUG 8'h2C

`endif
